// ==== files.f ====
hw/icache_pkg.sv
hw/sync_sram.sv
hw/cache_way.sv
hw/lru_table.sv
hw/icache_ctrl.sv
hw/icache_top.sv
verification/line_memory.sv
verification/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the icache testbench with Verilator, runs it and scans the log

BUILD_DIR=obj_dir
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module icache_tb -Mdir "$BUILD_DIR" -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vicache_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    exit 1
fi
exit 0

// ==== verification/icache_tb.sv ====
module icache_tb
    import icache_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEED         = 32'h7dbe_d544;
    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_DELAY    = 5;
    localparam int NUM_REQS     = 33;
    // Worst miss covers lookup, both memory delays, refill and the idle gap
    localparam int MISS_CYCLES  = 2 * (MAX_DELAY + 1) + 4;
    localparam int LIMIT_CYCLES = RESET_CYCLES + 2 * NUM_REQS * MISS_CYCLES;

    logic        clk;
    logic        resetn;
    logic        valid;
    tag_t        tag;
    index_t      index;
    offset_t     offset;
    logic        addr_ok;
    logic        data_ok;
    line_t       rdata;
    logic        rd_req;
    logic [31:0] rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    line_t       ret_data;

    int          seed;
    string       test_name = "reset";
    int          value_errors = 0;
    int          protocol_errors = 0;
    int          cycle = 0;
    logic [31:0] pend_addr [$];
    bit          pend_hit [$];
    int          pend_cycle [$];
    logic [31:0] stream_addrs [$];
    logic [31:0] resident_addrs [$];
    bit          req_seen = 1'b0;
    bit          req_held = 1'b0;
    logic [31:0] held_addr;

    // Reference model of two tags and one victim bit per set
    tag_t        model_tag [NUM_SETS][2];
    bit          model_vld [NUM_SETS][2];
    bit          model_victim [NUM_SETS];

    icache_top dut0 (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .tag       (tag),
        .index     (index),
        .offset    (offset),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data)
    );

    line_memory #(
        .SEED      (SEED),
        .MAX_DELAY (MAX_DELAY)
    ) mem_i (
        .clk       (clk),
        .resetn    (resetn),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(LIMIT_CYCLES * PERIOD);
        $display("Watchdog expired after %0d cycles, the cache stopped answering",
                 LIMIT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic logic [31:0] make_addr(input tag_t t, input index_t s, input offset_t o);
        return {t, s, o};
    endfunction

    function automatic logic [31:0] line_addr_of(input logic [31:0] addr);
        return {addr[31:OFFSET_W], {OFFSET_W{1'b0}}};
    endfunction

    function automatic line_t expected_line(input logic [31:0] addr);
        line_t l;
        int    i;
        for (i = 0; i < LINE_W / WORD_W; i++) begin
            l[i*WORD_W +: WORD_W] = addr + 32'(4 * i);
        end
        return l;
    endfunction

    // Returns the expected hit and updates the reference state
    function automatic bit model_access(input logic [31:0] addr);
        tag_t   t;
        index_t s;
        int     w;
        int     i;
        bit     h;
        t = addr[OFFSET_W+INDEX_W +: TAG_W];
        s = addr[OFFSET_W +: INDEX_W];
        h = 1'b0;
        w = 0;
        for (i = 0; i < 2; i++) begin
            if (model_vld[s][i] && model_tag[s][i] == t) begin
                h = 1'b1;
                w = i;
            end
        end
        if (!h) begin
            w = int'(model_victim[s]);
            model_tag[s][w] = t;
            model_vld[s][w] = 1'b1;
        end
        model_victim[s] = (w == 0);
        return h;
    endfunction

    task automatic report_mismatch(input string what, input line_t expected, input line_t actual);
        value_errors++;
        $display("[FAIL] %s: %s expected %0h actual %0h", test_name, what, expected, actual);
    endtask

    task automatic report_violation(input string what);
        protocol_errors++;
        $display("Error in %s at cycle %0d: %s", test_name, cycle, what);
    endtask

    task automatic drive_addr(input logic [31:0] addr);
        tag    <= addr[OFFSET_W+INDEX_W +: TAG_W];
        index  <= addr[OFFSET_W +: INDEX_W];
        offset <= addr[OFFSET_W-1:0];
    endtask

    // Single request that waits for its answer
    task automatic request(input logic [31:0] addr);
        drive_addr(addr);
        valid <= 1'b1;
        do @(posedge clk); while (!addr_ok);
        valid <= 1'b0;
        do @(posedge clk); while (!data_ok);
    endtask

    // valid stays high so each request waits only on addr_ok
    task automatic stream();
        int i;
        i = 0;
        drive_addr(stream_addrs[0]);
        valid <= 1'b1;
        while (i < stream_addrs.size()) begin
            @(posedge clk);
            if (addr_ok) begin
                i++;
                if (i < stream_addrs.size()) begin
                    drive_addr(stream_addrs[i]);
                end else begin
                    valid <= 1'b0;
                end
            end
        end
        do @(posedge clk); while (!data_ok);
    endtask

    always @(posedge clk) begin
        logic [31:0] acc_addr;
        line_t       exp_line;
        if (resetn) begin
            if (data_ok) begin
                assert (pend_addr.size() != 0)
                    else report_violation("data_ok with no request outstanding");
                if (pend_addr.size() != 0) begin
                    exp_line = expected_line(line_addr_of(pend_addr[0]));
                    assert (rdata == exp_line) else report_mismatch("rdata", exp_line, rdata);
                    if (pend_hit[0]) begin
                        assert (cycle == pend_cycle[0] + 1)
                            else report_violation("hit answered late");
                        assert (!valid || addr_ok)
                            else report_violation("hitting lookup refused the next request");
                    end else begin
                        assert (ret_valid) else report_violation("miss answered before ret_valid");
                        assert (req_seen) else report_violation("miss answered without rd_req");
                    end
                    void'(pend_addr.pop_front());
                    void'(pend_hit.pop_front());
                    void'(pend_cycle.pop_front());
                    req_seen = 1'b0;
                end
            end else if (pend_addr.size() != 0 && pend_hit[0]) begin
                assert (cycle != pend_cycle[0] + 1)
                    else report_violation("no data_ok one cycle after a hit");
            end
            if (rd_req) begin
                assert (pend_addr.size() != 0 && !pend_hit[0])
                    else report_violation("rd_req without an outstanding miss");
                if (pend_addr.size() != 0) begin
                    assert (rd_addr == line_addr_of(pend_addr[0]))
                        else report_mismatch("rd_addr", line_t'(line_addr_of(pend_addr[0])),
                                             line_t'(rd_addr));
                end
                req_seen = 1'b1;
            end
            if (req_held) begin
                assert (rd_req) else report_violation("rd_req dropped before rd_rdy");
                assert (rd_addr == held_addr)
                    else report_mismatch("held rd_addr", line_t'(held_addr), line_t'(rd_addr));
            end
            req_held  = rd_req && !rd_rdy;
            held_addr = rd_addr;
            if (valid && addr_ok) begin
                acc_addr = {tag, index, offset};
                pend_addr.push_back(acc_addr);
                pend_hit.push_back(model_access(acc_addr));
                pend_cycle.push_back(cycle);
            end
        end
        cycle = cycle + 1;
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] r;
        int          i;
        seed   = SEED;
        resetn = 1'b0;
        valid  = 1'b0;
        tag    = '0;
        index  = '0;
        offset = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);

        test_name = "cold_miss";
        a = make_addr(20'h12345, 7'd3, 5'h14);
        request(a);

        test_name = "hit";
        request(a);
        request(make_addr(20'h12345, 7'd3, 5'h00));

        test_name = "two_ways";
        a = make_addr(20'ha0001, 7'd9, 5'h04);
        b = make_addr(20'hb0002, 7'd9, 5'h1c);
        request(a);
        request(b);
        request(b);
        request(a);
        request(b);
        resident_addrs.push_back(a);
        resident_addrs.push_back(b);

        // C must evict B since A was used last
        test_name = "replacement";
        a = make_addr(20'h00aaa, 7'd20, 5'h08);
        b = make_addr(20'h00bbb, 7'd20, 5'h10);
        c = make_addr(20'h00ccc, 7'd20, 5'h00);
        request(a);
        request(b);
        request(a);
        request(c);
        request(a);
        request(b);
        resident_addrs.push_back(a);

        // Next request is already waiting while each miss is outstanding
        test_name = "back_pressure";
        for (i = 0; i < 8; i++) begin
            r = $random(seed);
            a = make_addr(r[TAG_W-1:0], index_t'(40 + i), r[31:27]);
            stream_addrs.push_back(a);
            resident_addrs.push_back(a);
        end
        stream();

        test_name = "pipelined_hits";
        stream_addrs = resident_addrs;
        stream();
        repeat (2) @(posedge clk);
        assert (pend_addr.size() == 0) else report_violation("requests left unanswered");

        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== verification/line_memory.sv ====
module line_memory
    import icache_pkg::*;
#(
    parameter int SEED      = 0,
    parameter int MAX_DELAY = 5
) (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              rd_req,
    input  logic [TAG_W+INDEX_W+OFFSET_W-1:0] rd_addr,
    output logic                              rd_rdy,
    output logic                              ret_valid,
    output line_t                             ret_data
);
    timeunit 1ns;
    timeprecision 1ps;

    int seed;

    // Word i of the line at address A holds A + 4i
    function automatic line_t line_of(input logic [31:0] addr);
        line_t l;
        int    i;
        for (i = 0; i < LINE_W / WORD_W; i++) begin
            l[i*WORD_W +: WORD_W] = addr + 32'(4 * i);
        end
        return l;
    endfunction

    function automatic int pick(input int lo, input int hi);
        int r;
        r = int'($unsigned($random(seed)) % (hi - lo + 1));
        return lo + r;
    endfunction

    initial begin
        logic [31:0] addr;
        int          wait_cycles;
        seed      = SEED;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        forever begin
            @(posedge clk);
            if (resetn && rd_req) begin
                addr = rd_addr;
                wait_cycles = pick(0, MAX_DELAY);
                repeat (wait_cycles) @(posedge clk);
                rd_rdy <= 1'b1;
                @(posedge clk);
                rd_rdy <= 1'b0;
                // Return delay counts from the handshake edge
                wait_cycles = pick(1, MAX_DELAY);
                repeat (wait_cycles - 1) @(posedge clk);
                ret_valid <= 1'b1;
                ret_data  <= line_of(addr);
                @(posedge clk);
                ret_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/icache_top.sv ====
module icache_top
    import icache_pkg::*;
(
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              valid,
    input  tag_t                              tag,
    input  index_t                            index,
    input  offset_t                           offset,
    output logic                              addr_ok,
    output logic                              data_ok,
    output line_t                             rdata,
    output logic                              rd_req,
    output logic [TAG_W+INDEX_W+OFFSET_W-1:0] rd_addr,
    input  logic                              rd_rdy,
    input  logic                              ret_valid,
    input  line_t                             ret_data
);

    logic       ram_en;
    index_t     ram_index;
    tag_t       rb_tag;
    index_t     rb_index;
    logic [1:0] way_hit;
    line_t      way0_line;
    line_t      way1_line;
    logic       victim;
    logic       refill_way0;
    logic       refill_way1;
    logic       hit_strobe;
    logic       hit_way;
    logic       refill_strobe;

    icache_ctrl ctrl_i (
        .clk           (clk),
        .resetn        (resetn),
        .valid         (valid),
        .tag           (tag),
        .index         (index),
        .offset        (offset),
        .addr_ok       (addr_ok),
        .data_ok       (data_ok),
        .rdata         (rdata),
        .rd_req        (rd_req),
        .rd_addr       (rd_addr),
        .rd_rdy        (rd_rdy),
        .ret_valid     (ret_valid),
        .ret_data      (ret_data),
        .ram_en        (ram_en),
        .ram_index     (ram_index),
        .rb_tag        (rb_tag),
        .rb_index      (rb_index),
        .way_hit       (way_hit),
        .way0_line     (way0_line),
        .way1_line     (way1_line),
        .victim        (victim),
        .refill_way0   (refill_way0),
        .refill_way1   (refill_way1),
        .hit_strobe    (hit_strobe),
        .hit_way       (hit_way),
        .refill_strobe (refill_strobe)
    );

    cache_way way0_i (
        .clk         (clk),
        .resetn      (resetn),
        .rd_en       (ram_en),
        .rd_index    (ram_index),
        .rb_tag      (rb_tag),
        .rb_index    (rb_index),
        .refill      (refill_way0),
        .refill_line (ret_data),
        .hit         (way_hit[0]),
        .line        (way0_line)
    );

    cache_way way1_i (
        .clk         (clk),
        .resetn      (resetn),
        .rd_en       (ram_en),
        .rd_index    (ram_index),
        .rb_tag      (rb_tag),
        .rb_index    (rb_index),
        .refill      (refill_way1),
        .refill_line (ret_data),
        .hit         (way_hit[1]),
        .line        (way1_line)
    );

    // Way 1 strobe doubles as the refilled way number
    lru_table lru_i (
        .clk           (clk),
        .resetn        (resetn),
        .index         (rb_index),
        .hit_strobe    (hit_strobe),
        .hit_way       (hit_way),
        .refill_strobe (refill_strobe),
        .refill_way    (refill_way1),
        .victim        (victim)
    );

endmodule

// ==== hw/icache_ctrl.sv ====
module icache_ctrl
    import icache_pkg::*;
(
    input  logic                              clk,
    input  logic                              resetn,
    // CPU side
    input  logic                              valid,
    input  tag_t                              tag,
    input  index_t                            index,
    input  offset_t                           offset,
    output logic                              addr_ok,
    output logic                              data_ok,
    output line_t                             rdata,
    // Memory side
    output logic                              rd_req,
    output logic [TAG_W+INDEX_W+OFFSET_W-1:0] rd_addr,
    input  logic                              rd_rdy,
    input  logic                              ret_valid,
    input  line_t                             ret_data,
    // Ways and replacement table
    output logic                              ram_en,
    output index_t                            ram_index,
    output tag_t                              rb_tag,
    output index_t                            rb_index,
    input  logic [1:0]                        way_hit,
    input  line_t                             way0_line,
    input  line_t                             way1_line,
    input  logic                              victim,
    output logic                              refill_way0,
    output logic                              refill_way1,
    output logic                              hit_strobe,
    output logic                              hit_way,
    output logic                              refill_strobe
);

    state_t  state;
    state_t  next_state;
    logic    rp_way;
    logic    cache_hit;
    logic    accept;
    logic    refill_done;

    assign cache_hit   = |way_hit;
    assign addr_ok     = valid && ((state == IDLE) || (state == LOOKUP && cache_hit));
    assign accept      = valid && addr_ok;
    assign refill_done = (state == REFILL) && ret_valid;

    // Lookup read starts in the accepting cycle
    assign ram_en    = accept;
    assign ram_index = index;

    always_ff @(posedge clk) begin
        if (accept) begin
            rb_tag   <= tag;
            rb_index <= index;
        end
    end

    // Victim sampled once the miss is known
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rp_way <= 1'b0;
        end else if (state == LOOKUP && !cache_hit) begin
            rp_way <= victim;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (accept) next_state = LOOKUP;
            end
            LOOKUP: begin
                if (!cache_hit) begin
                    next_state = REPLACE;
                end else if (!accept) begin
                    next_state = IDLE;
                end
            end
            REPLACE: begin
                if (rd_rdy) next_state = REFILL;
            end
            REFILL: begin
                if (ret_valid) next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    // Line address of the buffered request
    assign rd_addr = {rb_tag, rb_index, {OFFSET_W{1'b0}}};
    assign rd_req  = (state == REPLACE);

    assign refill_strobe = refill_done;
    assign refill_way0   = refill_done && !rp_way;
    assign refill_way1   = refill_done && rp_way;

    assign hit_strobe = (state == LOOKUP) && cache_hit;
    assign hit_way    = way_hit[1];

    assign data_ok = hit_strobe || refill_done;
    assign rdata   = (state == REFILL) ? ret_data :
                     way_hit[1]        ? way1_line : way0_line;

endmodule

// ==== hw/lru_table.sv ====
module lru_table
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   resetn,
    input  index_t index,
    input  logic   hit_strobe,
    input  logic   hit_way,
    input  logic   refill_strobe,
    input  logic   refill_way,
    output logic   victim
);

    // One bit per set names the way to evict next
    logic [NUM_SETS-1:0] victim_bits;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            victim_bits <= '0;
        end else if (hit_strobe) begin
            victim_bits[index] <= ~hit_way;
        end else if (refill_strobe) begin
            victim_bits[index] <= ~refill_way;
        end
    end

    assign victim = victim_bits[index];

endmodule

// ==== hw/cache_way.sv ====
module cache_way
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   resetn,
    input  logic   rd_en,
    input  index_t rd_index,
    input  tag_t   rb_tag,
    input  index_t rb_index,
    input  logic   refill,
    input  line_t  refill_line,
    output logic   hit,
    output line_t  line
);

    logic [NUM_SETS-1:0] valid_bits;
    tag_t                stored_tag;
    logic                ram_en;
    index_t              ram_addr;

    // Refill and lookup never overlap, refill takes the buffered index
    assign ram_en   = rd_en | refill;
    assign ram_addr = refill ? rb_index : rd_index;

    sync_sram #(
        .DEPTH     (NUM_SETS),
        .payload_t (tag_t)
    ) tag_ram (
        .clk  (clk),
        .en   (ram_en),
        .we   (refill),
        .addr (ram_addr),
        .din  (rb_tag),
        .dout (stored_tag)
    );

    sync_sram #(
        .DEPTH     (NUM_SETS),
        .payload_t (line_t)
    ) data_ram (
        .clk  (clk),
        .en   (ram_en),
        .we   (refill),
        .addr (ram_addr),
        .din  (refill_line),
        .dout (line)
    );

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
        end else if (refill) begin
            valid_bits[rb_index] <= 1'b1;
        end
    end

    assign hit = valid_bits[rb_index] && (stored_tag == rb_tag);

endmodule

// ==== hw/sync_sram.sv ====
module sync_sram
    import icache_pkg::*;
#(
    parameter int  DEPTH     = NUM_SETS,
    parameter type payload_t = line_t
) (
    input  logic     clk,
    input  logic     en,
    input  logic     we,
    input  index_t   addr,
    input  payload_t din,
    output payload_t dout
);

    payload_t mem [DEPTH];

    // Registered read, output holds while a write is in progress
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= din;
            end else begin
                dout <= mem[addr];
            end
        end
    end

endmodule

// ==== hw/icache_pkg.sv ====
package icache_pkg;

    // Address split: tag | index | byte offset
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 7;
    localparam int OFFSET_W = 5;

    localparam int NUM_SETS = 1 << INDEX_W;
    localparam int LINE_W   = 256;
    localparam int WORD_W   = 32;

    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [LINE_W-1:0]   line_t;

    // One-hot controller states
    typedef enum logic [3:0] {
        IDLE    = 4'b0001,
        LOOKUP  = 4'b0010,
        REPLACE = 4'b0100,
        REFILL  = 4'b1000
    } state_t;

endpackage
